//--- src/cdc_fifo_pkg.sv
// Package with FIFO sizing localparams, payload and pointer typedefs and the pop FSM state enum

package cdc_fifo_pkg;

  // --------------------------------------------------
  // Sizing
  // --------------------------------------------------

  // Number of entries held in the flop RAM
  localparam int DEPTH = 8;
  // RAM address width, log2 of DEPTH
  localparam int ADDR_WIDTH = 3;
  // Pointers carry one extra wrap bit so full and empty can be told apart
  localparam int PTR_WIDTH = ADDR_WIDTH + 1;
  // Flop stages a Gray pointer passes through in the destination domain
  localparam int NUM_SYNC_STAGES = 3;
  // Width of one FIFO entry
  localparam int DATA_WIDTH = 16;
  // Counters must reach DEPTH itself, hence one bit more than the address
  localparam int COUNT_WIDTH = 4;

  // --------------------------------------------------
  // Types
  // --------------------------------------------------

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  // Shared by binary and Gray encoded pointers
  typedef logic [PTR_WIDTH-1:0] ptr_t;
  // Slots, items and both credit counters
  typedef logic [COUNT_WIDTH-1:0] count_t;

  // Pop side output controller states
  typedef enum logic [1:0] {
    POP_IDLE,
    POP_FETCH,
    POP_HOLD
  } pop_state_t;

endpackage

//--- src/fifo_ram_if.sv
// Interface carrying the RAM write port and read port signals, with write, read and memory modports

`timescale 1ns/100ps

interface fifo_ram_if
  import cdc_fifo_pkg::*;
();

  // Write port, owned by the push domain
  logic  wr_valid;
  addr_t wr_addr;
  data_t wr_data;

  // Read address, owned by the pop domain
  logic  rd_addr_valid;
  addr_t rd_addr;

  // Read data returns one pop_clk cycle after the address
  logic  rd_data_valid;
  data_t rd_data;

  // Push controller drives the write port
  modport wr_side (
    output wr_valid, wr_addr, wr_data
  );

  // Pop FSM issues reads and takes the returned word
  modport rd_side (
    output rd_addr_valid, rd_addr,
    input  rd_data_valid, rd_data
  );

  // The storage array sees the other side of both ports
  modport mem (
    input  wr_valid, wr_addr, wr_data, rd_addr_valid, rd_addr,
    output rd_data_valid, rd_data
  );

endinterface

//--- src/gray_ptr_counter.sv
// Gray pointer counter: binary FIFO pointer with an enable and a registered Gray copy for the crossing

`timescale 1ns/100ps

module gray_ptr_counter
  import cdc_fifo_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic incr,
  output ptr_t ptr_bin,
  output ptr_t ptr_gray
);

  // --------------------------------------------------
  // Binary pointer
  // --------------------------------------------------

  // Wraps naturally at 2*DEPTH, the top bit marks odd laps
  always_ff @(posedge clk) begin
    if (reset) begin
      ptr_bin <= '0;
    end else if (incr) begin
      ptr_bin <= ptr_bin + 1'b1;
    end
  end

  // --------------------------------------------------
  // Gray register
  // --------------------------------------------------

  // The Gray copy comes straight from a flop so the other domain
  // never samples combinational glitches
  // Consecutive binary values differ in one Gray bit only, so a
  // synchronizer catching a transition sees either the old or the new value
  // This lags ptr_bin by one cycle, which also guarantees the RAM
  // write has landed before the pointer becomes visible elsewhere
  always_ff @(posedge clk) begin
    if (reset) begin
      ptr_gray <= '0;
    end else begin
      ptr_gray <= ptr_bin ^ (ptr_bin >> 1);
    end
  end

endmodule

//--- src/gray_ptr_sync.sv
// Gray pointer synchronizer: multi-flop crossing into the destination clock and Gray-to-binary decode

`timescale 1ns/100ps

module gray_ptr_sync
  import cdc_fifo_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  ptr_t gray_in,
  output ptr_t bin_out
);

  // Stage 0 is the only flop allowed to go metastable
  ptr_t sync_q [NUM_SYNC_STAGES];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= gray_in;
      for (int i = 1; i < NUM_SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // Binary bit i is the XOR of all Gray bits from i upward
  always_comb begin
    for (int i = 0; i < PTR_WIDTH; i++) begin
      bin_out[i] = ^(sync_q[NUM_SYNC_STAGES-1] >> i);
    end
  end

endmodule

//--- src/flop_ram_1r1w.sv
// Flop RAM with one write port on push_clk and one registered read port on pop_clk

`timescale 1ns/100ps

module flop_ram_1r1w
  import cdc_fifo_pkg::*;
(
  input logic    push_clk,
  input logic    pop_clk,
  input logic    pop_rst,
  fifo_ram_if.mem ram
);

  // Storage cells, written in the push domain
  // A cell is only read after its write pointer update has crossed over,
  // so the contents need no initial value
  data_t mem_q [DEPTH];

  // --------------------------------------------------
  // Write port
  // --------------------------------------------------

  always_ff @(posedge push_clk) begin
    if (ram.wr_valid) begin
      mem_q[ram.wr_addr] <= ram.wr_data;
    end
  end

  // --------------------------------------------------
  // Read port
  // --------------------------------------------------

  // Valid flag follows the address strobe by exactly one pop cycle
  always_ff @(posedge pop_clk) begin
    if (pop_rst) begin
      ram.rd_data_valid <= 1'b0;
    end else begin
      ram.rd_data_valid <= ram.rd_addr_valid;
    end
  end

  // Data register only moves on a read, idle cycles keep the last word
  always_ff @(posedge pop_clk) begin
    if (ram.rd_addr_valid) begin
      ram.rd_data <= mem_q[ram.rd_addr];
    end
  end

endmodule

//--- src/push_credit_ctrl.sv
// Push credit controller: occupancy, outstanding credit counter, credit pulses, RAM writes, push status

`timescale 1ns/100ps

module push_credit_ctrl
  import cdc_fifo_pkg::*;
(
  input  logic   push_clk,
  input  logic   push_rst,
  input  logic   push_credit_stall,
  input  logic   push_valid,
  input  data_t  push_data,
  input  ptr_t   rd_ptr_bin,
  input  ptr_t   wr_ptr_bin,
  output logic   wr_incr,
  output logic   push_credit,
  output logic   push_full,
  output count_t push_slots,
  output count_t credit_count_push,
  output count_t credit_available_push,
  fifo_ram_if.wr_side ram
);

  // Entries the push side still considers occupied
  count_t used_slots;
  // Decision to send a credit on the next cycle
  logic   credit_grant;

  // --------------------------------------------------
  // Occupancy
  // --------------------------------------------------

  // rd_ptr_bin is the synchronized read pointer, so it lags the pop side
  // This only ever overestimates occupancy, which is the safe direction
  assign used_slots = count_t'(wr_ptr_bin - rd_ptr_bin);
  assign push_slots = count_t'(DEPTH) - used_slots;
  assign push_full  = (push_slots == '0);

  // --------------------------------------------------
  // Credit accounting
  // --------------------------------------------------

  // Credits the sender holds but has not spent yet
  // A credit pulse and a push in the same cycle cancel out
  always_ff @(posedge push_clk) begin
    if (push_rst) begin
      credit_count_push <= '0;
    end else begin
      credit_count_push <= credit_count_push + count_t'(push_credit) - count_t'(push_valid);
    end
  end

  // Free slots not already promised to the sender
  // A push lowers push_slots and credit_count_push together, so this stays put
  assign credit_available_push = push_slots - credit_count_push;

  // The pulse currently on push_credit is not yet in the counter,
  // so it is subtracted here to avoid promising the same slot twice
  // This still allows a credit every cycle while two or more slots are free
  assign credit_grant = !push_credit_stall &&
                        (credit_available_push > count_t'(push_credit));

  // Registered pulse, so a stall raised now can still see one credit go out
  always_ff @(posedge push_clk) begin
    if (push_rst) begin
      push_credit <= 1'b0;
    end else begin
      push_credit <= credit_grant;
    end
  end

  // --------------------------------------------------
  // RAM write
  // --------------------------------------------------

  // Each push writes at the current pointer and moves the pointer on;
  // the sender only pushes with a credit in hand, so no check is done here
  assign ram.wr_valid = push_valid;
  assign ram.wr_addr  = wr_ptr_bin[ADDR_WIDTH-1:0];
  assign ram.wr_data  = push_data;
  assign wr_incr      = push_valid;

endmodule

//--- src/pop_output_fsm.sv
// Pop output FSM: fetches RAM entries into the pop output register, read pointer update, pop status

`timescale 1ns/100ps

module pop_output_fsm
  import cdc_fifo_pkg::*;
(
  input  logic   pop_clk,
  input  logic   pop_rst,
  input  logic   pop_ready,
  input  ptr_t   wr_ptr_bin,
  input  ptr_t   rd_ptr_bin,
  output logic   rd_incr,
  output logic   pop_valid,
  output data_t  pop_data,
  output logic   pop_empty,
  output count_t pop_items,
  fifo_ram_if.rd_side ram
);

  pop_state_t state_q;
  pop_state_t state_next;
  // Pointer of the next entry still sitting in the RAM
  ptr_t       fetch_ptr;
  // Entries in the RAM that have not been fetched yet
  ptr_t       fetchable;
  logic       pop_xfer;
  logic       fetch;

  // --------------------------------------------------
  // Pointer bookkeeping
  // --------------------------------------------------

  // rd_ptr_bin counts entries that have left through the pop port
  // The slot of the entry in flight or in the output register is only
  // handed back to the push side once that entry is popped
  // So the whole FIFO, output register included, never holds more than DEPTH
  assign pop_xfer = pop_valid && pop_ready;
  assign rd_incr  = pop_xfer;

  // Outside POP_IDLE exactly one entry sits beyond the read pointer
  assign fetch_ptr = rd_ptr_bin + ptr_t'(state_q != POP_IDLE);
  assign fetchable = wr_ptr_bin - fetch_ptr;

  // Refill when the output is empty, or back to back when it is being taken
  assign fetch = (fetchable != '0) &&
                 ((state_q == POP_IDLE) || ((state_q == POP_HOLD) && pop_ready));

  assign ram.rd_addr_valid = fetch;
  assign ram.rd_addr       = fetch_ptr[ADDR_WIDTH-1:0];

  // --------------------------------------------------
  // FSM
  // --------------------------------------------------

  always_comb begin
    state_next = state_q;
    case (state_q)
      POP_IDLE: begin
        if (fetch) begin
          state_next = POP_FETCH;
        end
      end
      // Read data always returns the cycle after the address
      POP_FETCH: begin
        if (ram.rd_data_valid) begin
          state_next = POP_HOLD;
        end
      end
      POP_HOLD: begin
        if (pop_ready) begin
          state_next = fetch ? POP_FETCH : POP_IDLE;
        end
      end
      default: state_next = POP_IDLE;
    endcase
  end

  always_ff @(posedge pop_clk) begin
    if (pop_rst) begin
      state_q <= POP_IDLE;
    end else begin
      state_q <= state_next;
    end
  end

  // --------------------------------------------------
  // Output register
  // --------------------------------------------------

  // pop_valid is a flop copy of being in POP_HOLD
  always_ff @(posedge pop_clk) begin
    if (pop_rst) begin
      pop_valid <= 1'b0;
    end else begin
      pop_valid <= (state_next == POP_HOLD);
    end
  end

  // Only a returning read loads the register, so it holds under back-pressure
  always_ff @(posedge pop_clk) begin
    if (ram.rd_data_valid) begin
      pop_data <= ram.rd_data;
    end
  end

  // Everything not yet popped, whether in RAM, in flight or on the output
  assign pop_items = count_t'(wr_ptr_bin - rd_ptr_bin);
  assign pop_empty = (pop_items == '0);

endmodule

//--- src/cdc_fifo_push_credit_top.sv
// CDC FIFO top level: pointer counters, pointer synchronizers, flop RAM, push and pop controllers

`timescale 1ns/100ps

module cdc_fifo_push_credit_top
  import cdc_fifo_pkg::*;
(
  // Push clock domain
  input  logic   push_clk,
  input  logic   push_rst,
  input  logic   push_credit_stall,
  output logic   push_credit,
  input  logic   push_valid,
  input  data_t  push_data,
  output logic   push_full,
  output count_t push_slots,
  output count_t credit_count_push,
  output count_t credit_available_push,

  // Pop clock domain
  input  logic   pop_clk,
  input  logic   pop_rst,
  input  logic   pop_ready,
  output logic   pop_valid,
  output data_t  pop_data,
  output logic   pop_empty,
  output count_t pop_items
);

  // Write port lives in push_clk, read port in pop_clk
  fifo_ram_if ram_bus ();

  // Write pointer, native in push_clk and synced copy in pop_clk
  logic wr_incr;
  ptr_t wr_ptr_bin;
  ptr_t wr_ptr_gray;
  ptr_t wr_ptr_bin_pop;

  // Read pointer, native in pop_clk and synced copy in push_clk
  logic rd_incr;
  ptr_t rd_ptr_bin;
  ptr_t rd_ptr_gray;
  ptr_t rd_ptr_bin_push;

  // --------------------------------------------------
  // Push domain
  // --------------------------------------------------

  gray_ptr_counter u_wr_ptr (
    .clk      (push_clk),
    .reset    (push_rst),
    .incr     (wr_incr),
    .ptr_bin  (wr_ptr_bin),
    .ptr_gray (wr_ptr_gray)
  );

  gray_ptr_sync u_rd_ptr_sync (
    .clk     (push_clk),
    .reset   (push_rst),
    .gray_in (rd_ptr_gray),
    .bin_out (rd_ptr_bin_push)
  );

  push_credit_ctrl u_push_ctrl (
    .push_clk              (push_clk),
    .push_rst              (push_rst),
    .push_credit_stall     (push_credit_stall),
    .push_valid            (push_valid),
    .push_data             (push_data),
    .rd_ptr_bin            (rd_ptr_bin_push),
    .wr_ptr_bin            (wr_ptr_bin),
    .wr_incr               (wr_incr),
    .push_credit           (push_credit),
    .push_full             (push_full),
    .push_slots            (push_slots),
    .credit_count_push     (credit_count_push),
    .credit_available_push (credit_available_push),
    .ram                   (ram_bus.wr_side)
  );

  // --------------------------------------------------
  // Storage, spans both clocks
  // --------------------------------------------------

  flop_ram_1r1w u_ram (
    .push_clk (push_clk),
    .pop_clk  (pop_clk),
    .pop_rst  (pop_rst),
    .ram      (ram_bus.mem)
  );

  // --------------------------------------------------
  // Pop domain
  // --------------------------------------------------

  gray_ptr_counter u_rd_ptr (
    .clk      (pop_clk),
    .reset    (pop_rst),
    .incr     (rd_incr),
    .ptr_bin  (rd_ptr_bin),
    .ptr_gray (rd_ptr_gray)
  );

  gray_ptr_sync u_wr_ptr_sync (
    .clk     (pop_clk),
    .reset   (pop_rst),
    .gray_in (wr_ptr_gray),
    .bin_out (wr_ptr_bin_pop)
  );

  pop_output_fsm u_pop_fsm (
    .pop_clk    (pop_clk),
    .pop_rst    (pop_rst),
    .pop_ready  (pop_ready),
    .wr_ptr_bin (wr_ptr_bin_pop),
    .rd_ptr_bin (rd_ptr_bin),
    .rd_incr    (rd_incr),
    .pop_valid  (pop_valid),
    .pop_data   (pop_data),
    .pop_empty  (pop_empty),
    .pop_items  (pop_items),
    .ram        (ram_bus.rd_side)
  );

endmodule

//--- verification/tb_cdc_fifo.sv
// Testbench for the CDC FIFO: clocks, resets, credit-based sender, pop checker, timeout

`timescale 1ns/100ps

module tb_cdc_fifo
  import cdc_fifo_pkg::*;
();

  // --------------------------------------------------
  // Constants
  // --------------------------------------------------

  localparam int NUM_WORDS = 32;
  localparam int IDX_W = $clog2(NUM_WORDS);
  // Worst case of 40 push cycles per word plus reset and settling
  localparam int TIMEOUT_CYCLES = NUM_WORDS * 40 + 200;
  localparam logic [31:0] RNG_SEED = 32'h9cca_e95d;

  // Test phases select pushing, pop_ready and push_credit_stall
  localparam int PH_IDLE = 0;
  localparam int PH_BACKPRESSURE = 1;
  localparam int PH_STALL = 2;
  localparam int PH_RELEASE = 3;
  localparam int PH_RANDOM = 4;
  localparam int PH_DRAIN = 5;

  // DUT inputs start at their idle values
  logic   push_clk = 1'b0;
  logic   pop_clk = 1'b0;
  logic   push_rst = 1'b1;
  logic   pop_rst = 1'b1;
  logic   push_credit_stall = 1'b0;
  logic   push_valid = 1'b0;
  data_t  push_data = '0;
  logic   pop_ready = 1'b0;
  logic   push_credit;
  logic   push_full;
  count_t push_slots;
  count_t credit_count_push;
  count_t credit_available_push;
  logic   pop_valid;
  data_t  pop_data;
  logic   pop_empty;
  count_t pop_items;

  // The golden stream is both the push data and the expected pop order
  data_t golden [NUM_WORDS];

  // Sender, pop checker and timeout bookkeeping
  int          phase = PH_IDLE;
  logic        push_run = 1'b0;
  logic        pop_run = 1'b0;
  int          held_credits = 0;
  int          credits_total = 0;
  int          push_idx = 0;
  int          pop_count = 0;
  int          cycle_count = 0;
  logic        last_valid = 1'b0;
  logic        last_ready = 1'b0;
  data_t       last_data = '0;
  logic [31:0] push_rnd;
  logic [31:0] pop_rnd;

  cdc_fifo_push_credit_top u_dut (
    .push_clk              (push_clk),
    .push_rst              (push_rst),
    .push_credit_stall     (push_credit_stall),
    .push_credit           (push_credit),
    .push_valid            (push_valid),
    .push_data             (push_data),
    .push_full             (push_full),
    .push_slots            (push_slots),
    .credit_count_push     (credit_count_push),
    .credit_available_push (credit_available_push),
    .pop_clk               (pop_clk),
    .pop_rst               (pop_rst),
    .pop_ready             (pop_ready),
    .pop_valid             (pop_valid),
    .pop_data              (pop_data),
    .pop_empty             (pop_empty),
    .pop_items             (pop_items)
  );

  // Push clock at 4 ns
  initial begin
    forever #2 push_clk = ~push_clk;
  end

  // Pop clock at 6 ns with a half ns offset so that no edge meets a push edge
  initial begin
    #0.5;
    forever #3 pop_clk = ~pop_clk;
  end

  // --------------------------------------------------
  // Error reporting helpers
  // --------------------------------------------------

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic expect_count(input string name, input count_t got, input count_t exp);
    assert (got == exp)
      else stop_on_error($sformatf("[ERROR] %s: expected 0x%h, got 0x%h", name, exp, got));
  endtask

  task automatic expect_bit(input string name, input logic got, input logic exp);
    assert (got == exp)
      else stop_on_error($sformatf("[ERROR] %s: expected 0x%h, got 0x%h", name, exp, got));
  endtask

  task automatic expect_data(input string name, input data_t got, input data_t exp);
    assert (got == exp)
      else stop_on_error($sformatf("[ERROR] %s: expected 0x%h, got 0x%h", name, exp, got));
  endtask

  task automatic expect_int(input string name, input int got, input int exp);
    assert (got == exp)
      else stop_on_error($sformatf("[ERROR] %s: expected 0x%h, got 0x%h", name, exp, got));
  endtask

  // Main flow steps one ns after a falling push edge and so stays clear of every clock edge
  task automatic settle();
    @(negedge push_clk);
    #1;
  endtask

  // --------------------------------------------------
  // Push side: sender and checks
  // --------------------------------------------------

  always @(negedge push_clk) begin
    if (push_run) begin
      assert (int'(credit_available_push) + int'(credit_count_push) == int'(push_slots))
        else stop_on_error($sformatf(
          "[ERROR] credit_available_push + credit_count_push: 0x%h + 0x%h, push_slots 0x%h",
          credit_available_push, credit_count_push, push_slots));
      assert (push_slots <= count_t'(DEPTH))
        else stop_on_error($sformatf("[ERROR] push_slots: above DEPTH, got 0x%h", push_slots));
      expect_bit("push_full", push_full, push_slots == '0);
      // Neither the tally nor the DUT counter includes this cycle's pulse and push yet
      expect_count("credit_count_push", credit_count_push, count_t'(held_credits));
      // A stall seen at the last rising edge blocks the pulse now on the wire
      if (push_credit_stall) begin
        expect_bit("push_credit", push_credit, 1'b0);
      end
      // Spend a credit received earlier and never the one arriving now
      if (phase != PH_IDLE && held_credits > 0 && push_idx < NUM_WORDS) begin
        push_valid = 1'b1;
        push_data = golden[push_idx[IDX_W-1:0]];
        push_idx++;
        held_credits--;
      end else begin
        push_valid = 1'b0;
      end
      if (push_credit) begin
        held_credits++;
        credits_total++;
      end
      push_rnd = $urandom();
      case (phase)
        PH_STALL, PH_DRAIN: push_credit_stall = 1'b1;
        PH_RANDOM: push_credit_stall = push_rnd[0];
        default: push_credit_stall = 1'b0;
      endcase
    end
  end

  // --------------------------------------------------
  // Pop side: pop_ready and ordering checks
  // --------------------------------------------------

  always @(negedge pop_clk) begin
    if (pop_run) begin
      expect_bit("pop_empty", pop_empty, pop_items == '0);
      // Output must hold while it was offered and not taken
      if (last_valid && !last_ready) begin
        expect_bit("pop_valid", pop_valid, 1'b1);
        expect_data("pop_data", pop_data, last_data);
      end
      pop_rnd = $urandom();
      case (phase)
        PH_STALL, PH_RELEASE, PH_DRAIN: pop_ready = 1'b1;
        PH_RANDOM: pop_ready = pop_rnd[0];
        default: pop_ready = 1'b0;
      endcase
      // pop_data is stable until the next rising edge where this transfer happens
      if (pop_valid && pop_ready) begin
        assert (pop_count < NUM_WORDS)
          else stop_on_error("A pop transfer arrived after all golden words were received");
        expect_data("pop_data", pop_data, golden[pop_count[IDX_W-1:0]]);
        pop_count++;
      end
      last_valid = pop_valid;
      last_ready = pop_ready;
      last_data = pop_data;
    end
  end

  // Run limit in push cycles
  always @(negedge push_clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      stop_on_error($sformatf("Timeout: the test did not finish within %0d push_clk cycles",
                              TIMEOUT_CYCLES));
    end
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------

  initial begin
    void'($urandom(RNG_SEED));
    $readmemh("verification/cdc_fifo_golden.hex", golden);
    // Each reset lasts 4 cycles of its own clock
    fork
      begin
        repeat (4) @(negedge push_clk);
        push_rst = 1'b0;
        #1;
        push_run = 1'b1;
      end
      begin
        repeat (4) @(negedge pop_clk);
        pop_rst = 1'b0;
        #1;
        pop_run = 1'b1;
      end
    join

    // After reset the sender is offered exactly DEPTH credits
    while (credits_total < DEPTH) settle();
    repeat (2 * DEPTH) settle();
    expect_int("push_credit pulses", credits_total, DEPTH);
    expect_count("credit_count_push", credit_count_push, count_t'(DEPTH));
    expect_count("credit_available_push", credit_available_push, '0);
    expect_count("push_slots", push_slots, count_t'(DEPTH));
    expect_bit("pop_empty", pop_empty, 1'b1);

    // Fill the FIFO with pop_ready low
    phase = PH_BACKPRESSURE;
    while (push_idx < DEPTH) settle();
    while (!pop_valid) settle();
    repeat (2 * DEPTH) begin
      settle();
      expect_bit("push_full", push_full, 1'b1);
      expect_bit("pop_valid", pop_valid, 1'b1);
      expect_data("pop_data", pop_data, golden[0]);
    end
    expect_int("push_credit pulses", credits_total, DEPTH);
    expect_count("credit_count_push", credit_count_push, '0);
    expect_count("pop_items", pop_items, count_t'(DEPTH));

    // Drain under a held stall where the freed slots must not produce credits
    phase = PH_STALL;
    while (pop_count < DEPTH || push_slots != count_t'(DEPTH)) settle();
    expect_int("push_credit pulses", credits_total, DEPTH);

    // Credits come back once the stall drops
    phase = PH_RELEASE;
    while (credits_total == DEPTH) settle();

    // Random pop_ready and push_credit_stall for the rest of the stream
    phase = PH_RANDOM;
    while (pop_count < NUM_WORDS) settle();

    // Final state once every word has gone through
    phase = PH_DRAIN;
    repeat (4) settle();
    while (push_slots != count_t'(DEPTH)) settle();
    expect_int("pushed words", push_idx, NUM_WORDS);
    expect_count("pop_items", pop_items, '0);
    expect_bit("pop_empty", pop_empty, 1'b1);
    expect_bit("push_full", push_full, 1'b0);
    expect_count("credit_count_push", credit_count_push, count_t'(held_credits));

    $display("Everything OK");
    $finish;
  end

endmodule

//--- sim.f
src/cdc_fifo_pkg.sv
src/fifo_ram_if.sv
src/gray_ptr_counter.sv
src/gray_ptr_sync.sv
src/flop_ram_1r1w.sv
src/push_credit_ctrl.sv
src/pop_output_fsm.sv
src/cdc_fifo_push_credit_top.sv
verification/tb_cdc_fifo.sv

//--- run_sim.sh
#!/bin/sh
# Builds the CDC FIFO testbench with Verilator, runs it and scans the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_cdc_fifo -f sim.f

# The log is checked below, so the run itself may end with any status
./obj_dir/Vtb_cdc_fifo > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi

echo "Simulation passed"
exit 0

//--- verification/cdc_fifo_golden.hex
// One 16-bit hex word per line, in push order
// The same sequence is the expected order at the pop port
a5c3
0000
ffff
1234
5a5a
a5a5
0001
8000
7fff
fffe
0f0f
f0f0
beef
cafe
dead
3c3c
c3c3
0102
0204
0408
0810
1020
2040
4080
8001
6b2d
9e17
d4e1
2b7a
71c8
e6f3
0bad
